// File: source/ppu_timing_pkg.sv
`default_nettype none

package ppu_timing_pkg;

	////////////////////////////////////////////////////////////
	// beam position and decoder vectors
	////////////////////////////////////////////////////////////

	typedef logic [8:0]  hpos_t; // dot within a scanline from 0 to 340.
	typedef logic [8:0]  vpos_t; // scanline within a frame from 0 to 261.
	typedef logic [23:0] hdec_t; // horizontal PLA match lines.
	typedef logic [8:0]  vdec_t; // vertical PLA match lines.

	// horizontal match lines that the timing logic consumes.
	localparam int HDEC_HSYNC_ON  = 0;  // H=279.
	localparam int HDEC_VIS_END   = 1;  // H=256.
	localparam int HDEC_VISIBLE   = 10; // H<256 with VB and BLNK low.
	localparam int HDEC_HSYNC_OFF = 20; // H=304.
	localparam int HDEC_LINE_END  = 23; // H=340.

	// vertical match lines.
	localparam int VDEC_VSYNC     = 0; // V=247.
	localparam int VDEC_FRAME_END = 2; // V=261.
	localparam int VDEC_VB_START  = 3; // V=241.

	////////////////////////////////////////////////////////////
	// landmarks that the PLA terms decode
	////////////////////////////////////////////////////////////

	localparam int H_DOTS      = 341;
	localparam int V_LINES     = 262;
	localparam int H_VISIBLE   = 256;
	localparam int H_HSYNC_ON  = 279;
	localparam int H_HSYNC_OFF = 304;
	localparam int V_VB_START  = 241;
	localparam int V_VSYNC     = 247;

endpackage

`default_nettype wire

// File: source/ppu_regs_pkg.sv
`default_nettype none

package ppu_regs_pkg;

	typedef logic [31:0] apb_data_t;
	typedef logic [11:0] apb_addr_t;

	// register byte offsets.
	localparam apb_addr_t CTRL_OFS   = 12'h000;
	localparam apb_addr_t STATUS_OFS = 12'h004;
	localparam apb_addr_t POS_OFS    = 12'h008;

	// CTRL fields.
	localparam int CTRL_RENDER_BIT = 0; // set to let dots through.
	localparam int CTRL_IRQ_EN_BIT = 1;

	// STATUS fields.
	localparam int STATUS_VBL_BIT = 0; // sticky until it is read.

	// POS holds H in bits 8:0 and V from this bit up.
	localparam int POS_V_LSB = 16;

endpackage

`default_nettype wire

// File: source/hv_counters.sv
`timescale 1ns/1ps
`default_nettype none

module hv_counters (
	input  logic                  pclk,
	input  logic                  rst_n,
	input  ppu_timing_pkg::hdec_t hdec,
	input  ppu_timing_pkg::vdec_t vdec,
	output ppu_timing_pkg::hpos_t h,
	output ppu_timing_pkg::vpos_t v
);

	logic line_end;
	logic frame_end;

	// the wrap points come out of the PLA, not from compares here.
	assign line_end  = hdec[ppu_timing_pkg::HDEC_LINE_END];
	assign frame_end = vdec[ppu_timing_pkg::VDEC_FRAME_END];

	////////////////////////////////////////////////////////////
	// dot counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			h <= '0;
		end else if (line_end) begin
			h <= '0;
		end else begin
			h <= h + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// scanline counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			v <= '0;
		end else if (line_end) begin
			if (frame_end) begin
				v <= '0; // last dot of line 261 starts a new frame.
			end else begin
				v <= v + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/h_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module h_decoder (
	input  ppu_timing_pkg::hpos_t h,
	input  logic                  vb,
	input  logic                  blnk,
	output ppu_timing_pkg::hdec_t hdec
);

	ppu_timing_pkg::hpos_t nh;

	assign nh = ~h;

	// each line is a NOR product term over true and inverted H bits.
	assign hdec[0]  = ~(nh[0] | nh[1] | nh[2] | h[3] | nh[4] | h[5] | h[6] | h[7] | nh[8]);
	assign hdec[1]  = ~(h[0] | h[1] | h[2] | h[3] | h[4] | h[5] | h[6] | h[7] | nh[8]);
	assign hdec[2]  = ~(nh[0] | h[1] | h[2] | h[3] | h[4] | h[5] | nh[6] | h[7] | h[8] | blnk);
	assign hdec[3]  = ~(h[3] | h[4] | h[5] | h[6] | h[7]);

	assign hdec[4]  = ~(h[8] | vb);
	assign hdec[5]  = ~(nh[0] | nh[1] | h[2] | h[3] | nh[4] | h[5] | nh[6] | h[7] | nh[8]
		| blnk);

	assign hdec[6]  = ~(nh[0] | nh[1] | nh[2] | nh[3] | nh[4] | nh[5] | h[6] | h[7] | h[8]
		| blnk);
	assign hdec[7]  = ~(nh[0] | nh[1] | nh[2] | nh[3] | nh[4] | nh[5] | nh[6] | nh[7]
		| blnk);
	assign hdec[8]  = ~(h[6] | h[7] | h[8] | blnk);

	assign hdec[9]  = ~(h[6] | h[7] | nh[8] | blnk);
	assign hdec[10] = ~(h[8] | vb | blnk); // the dot is on screen.
	assign hdec[11] = ~(h[1] | h[2] | blnk);
	assign hdec[12] = ~(nh[1] | nh[2]);
	assign hdec[13] = ~(h[1] | nh[2]);

	assign hdec[14] = ~(h[4] | h[5] | nh[6] | nh[8] | blnk);
	assign hdec[15] = ~(h[8] | blnk);
	assign hdec[16] = ~(nh[1] | h[2]);
	assign hdec[17] = ~(h[0] | nh[1] | nh[2] | nh[3] | h[4] | h[5] | h[6] | h[7] | nh[8]);
	assign hdec[18] = ~(h[0] | h[1] | h[2] | nh[3] | h[4] | h[5] | nh[6] | h[7] | nh[8]);

	assign hdec[19] = ~(nh[0] | nh[1] | nh[2] | h[3] | nh[4] | h[5] | h[6] | h[7] | nh[8]);
	assign hdec[20] = ~(h[0] | h[1] | h[2] | h[3] | nh[4] | nh[5] | h[6] | h[7] | nh[8]);
	assign hdec[21] = ~(nh[0] | nh[1] | h[2] | h[3] | h[4] | h[5] | nh[6] | h[7] | nh[8]);
	assign hdec[22] = ~(h[0] | h[1] | nh[2] | h[3] | nh[4] | nh[5] | h[6] | h[7] | nh[8]);
	assign hdec[23] = ~(h[0] | h[1] | nh[2] | h[3] | nh[4] | h[5] | nh[6] | h[7] | nh[8]);

endmodule

`default_nettype wire

// File: source/v_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module v_decoder (
	input  ppu_timing_pkg::vpos_t v,
	output ppu_timing_pkg::vdec_t vdec
);

	ppu_timing_pkg::vpos_t nv;

	assign nv = ~v;

	// terms without V[8] also match 256 lines further on, which never happens.
	assign vdec[0] = ~(nv[0] | nv[1] | nv[2] | v[3] | nv[4] | nv[5] | nv[6] | nv[7]);
	assign vdec[1] = ~(v[0] | v[1] | nv[2] | v[3] | nv[4] | nv[5] | nv[6] | nv[7]);
	assign vdec[2] = ~(nv[0] | v[1] | nv[2] | v[3] | v[4] | v[5] | v[6] | v[7] | nv[8]);

	assign vdec[3] = ~(nv[0] | v[1] | v[2] | v[3] | nv[4] | nv[5] | nv[6] | nv[7]);
	assign vdec[4] = ~(nv[0] | v[1] | v[2] | v[3] | nv[4] | nv[5] | nv[6] | nv[7]);
	assign vdec[5] = ~(v[0] | v[1] | v[2] | v[3] | v[4] | v[5] | v[6] | v[7] | v[8]);
	assign vdec[6] = ~(v[0] | v[1] | v[2] | v[3] | nv[4] | nv[5] | nv[6] | nv[7]);
	assign vdec[7] = ~(nv[0] | v[1] | nv[2] | v[3] | v[4] | v[5] | v[6] | v[7] | nv[8]);

	assign vdec[8] = ~(nv[0] | v[1] | nv[2] | v[3] | v[4] | v[5] | v[6] | v[7] | nv[8]);

endmodule

`default_nettype wire

// File: source/sync_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sync_gen (
	input  logic                  pclk,
	input  logic                  rst_n,
	input  ppu_timing_pkg::hdec_t hdec,
	input  ppu_timing_pkg::vdec_t vdec,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  vblank,
	output logic                  visible
);

	logic hs_set;
	logic hs_clr;
	logic vb_set;
	logic vb_clr;

	assign hs_set = hdec[ppu_timing_pkg::HDEC_HSYNC_ON];
	assign hs_clr = hdec[ppu_timing_pkg::HDEC_HSYNC_OFF];

	// vertical blank toggles at the end of the visible part of a line.
	assign vb_set = vdec[ppu_timing_pkg::VDEC_VB_START] & hdec[ppu_timing_pkg::HDEC_VIS_END];
	assign vb_clr = vdec[ppu_timing_pkg::VDEC_FRAME_END] & hdec[ppu_timing_pkg::HDEC_VIS_END];

	////////////////////////////////////////////////////////////
	// set/reset flip-flops
	////////////////////////////////////////////////////////////

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			hsync  <= 1'b0;
			vblank <= 1'b0;
		end else begin
			if (hs_set) begin
				hsync <= 1'b1;
			end else if (hs_clr) begin
				hsync <= 1'b0;
			end
			if (vb_set) begin
				vblank <= 1'b1;
			end else if (vb_clr) begin
				vblank <= 1'b0;
			end
		end
	end

	// single lines are registered one cycle late.
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			vsync   <= 1'b0;
			visible <= 1'b0;
		end else begin
			vsync   <= vdec[ppu_timing_pkg::VDEC_VSYNC]; // whole of line 247.
			visible <= hdec[ppu_timing_pkg::HDEC_VISIBLE];
		end
	end

endmodule

`default_nettype wire

// File: source/ppu_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_apb_regs #(
	parameter int ADDR_W = 12
) (
	input  logic                    pclk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  ppu_regs_pkg::apb_addr_t paddr,
	input  ppu_regs_pkg::apb_data_t pwdata,
	output ppu_regs_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	input  ppu_timing_pkg::hpos_t   h,
	input  ppu_timing_pkg::vpos_t   v,
	input  logic                    vblank,
	output logic                    blnk,
	output logic                    irq
);

	logic [ADDR_W-1:0] ofs;
	logic              access;
	logic              hit_ctrl;
	logic              hit_status;
	logic              hit_pos;
	logic              render_en;
	logic              irq_en;
	logic              vblank_q;
	logic              vbl_flag;
	logic              vbl_rise;

	assign ofs        = paddr[ADDR_W-1:0];
	assign access     = psel & penable; // pready is tied high.
	assign hit_ctrl   = (ofs == ADDR_W'(ppu_regs_pkg::CTRL_OFS));
	assign hit_status = (ofs == ADDR_W'(ppu_regs_pkg::STATUS_OFS));
	assign hit_pos    = (ofs == ADDR_W'(ppu_regs_pkg::POS_OFS));

	assign pready  = 1'b1;
	assign pslverr = access & ~(hit_ctrl | hit_status | hit_pos);
	assign blnk    = ~render_en;

	always_comb begin
		prdata = '0;
		if (hit_ctrl) begin
			prdata[ppu_regs_pkg::CTRL_RENDER_BIT] = render_en;
			prdata[ppu_regs_pkg::CTRL_IRQ_EN_BIT] = irq_en;
		end else if (hit_status) begin
			prdata[ppu_regs_pkg::STATUS_VBL_BIT] = vbl_flag;
		end else if (hit_pos) begin
			prdata[$bits(ppu_timing_pkg::hpos_t)-1:0] = h;
			prdata[ppu_regs_pkg::POS_V_LSB +: $bits(ppu_timing_pkg::vpos_t)] = v;
		end
	end

	////////////////////////////////////////////////////////////
	// control, status and interrupt
	////////////////////////////////////////////////////////////

	assign vbl_rise = vblank & ~vblank_q;

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			render_en <= 1'b0;
			irq_en    <= 1'b0;
			vblank_q  <= 1'b0;
			vbl_flag  <= 1'b0;
			irq       <= 1'b0;
		end else begin
			if (access && pwrite && hit_ctrl) begin
				render_en <= pwdata[ppu_regs_pkg::CTRL_RENDER_BIT];
				irq_en    <= pwdata[ppu_regs_pkg::CTRL_IRQ_EN_BIT];
			end
			vblank_q <= vblank;
			if (vbl_rise) begin
				vbl_flag <= 1'b1; // a new frame's blank beats a read in flight.
			end else if (access && !pwrite && hit_status) begin
				vbl_flag <= 1'b0;
			end
			irq <= vbl_flag & irq_en;
		end
	end

endmodule

`default_nettype wire

// File: source/ppu_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_timing_top #(
	parameter int ADDR_W = 12
) (
	input  logic                    pclk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  ppu_regs_pkg::apb_addr_t paddr,
	input  ppu_regs_pkg::apb_data_t pwdata,
	output ppu_regs_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    vblank,
	output logic                    visible,
	output logic                    irq
);

	ppu_timing_pkg::hpos_t h;
	ppu_timing_pkg::vpos_t v;
	ppu_timing_pkg::hdec_t hdec;
	ppu_timing_pkg::vdec_t vdec;
	logic                  blnk;

	hv_counters counters_i (
		.pclk(pclk), .rst_n(rst_n), .hdec(hdec), .vdec(vdec), .h(h), .v(v)
	);

	// vblank loops back into the horizontal PLA as VB.
	h_decoder hpla_i (.h(h), .vb(vblank), .blnk(blnk), .hdec(hdec));

	v_decoder vpla_i (.v(v), .vdec(vdec));

	sync_gen sync_i (
		.pclk(pclk), .rst_n(rst_n), .hdec(hdec), .vdec(vdec),
		.hsync(hsync), .vsync(vsync), .vblank(vblank), .visible(visible)
	);

	ppu_apb_regs #(
		.ADDR_W(ADDR_W)
	) regs_i (
		.pclk(pclk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.h(h), .v(v), .vblank(vblank), .blnk(blnk), .irq(irq)
	);

endmodule

`default_nettype wire

// File: dv/ppu_timing_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_timing_tb;

	localparam int CLK_NS      = 40;
	localparam int FRAME       = ppu_timing_pkg::H_DOTS * ppu_timing_pkg::V_LINES;
	localparam int RUN_CYCLES  = 3 * FRAME;
	localparam int WATCHDOG_NS = ((7 * FRAME) / 2 + 1000) * CLK_NS; // 3.5 frames and a margin.

	logic                    pclk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	ppu_regs_pkg::apb_addr_t paddr;
	ppu_regs_pkg::apb_data_t pwdata;
	ppu_regs_pkg::apb_data_t prdata;
	logic                    pready;
	logic                    pslverr;
	logic                    hsync;
	logic                    vsync;
	logic                    vblank;
	logic                    visible;
	logic                    irq;

	// the model holds the values that the DUT should show before the next edge.
	ppu_timing_pkg::hpos_t m_h;
	ppu_timing_pkg::vpos_t m_v;
	logic                  m_hsync;
	logic                  m_vsync;
	logic                  m_vblank;
	logic                  m_vblank_q;
	logic                  m_visible;
	logic                  m_flag;
	logic                  m_irq;
	logic                  m_render;
	logic                  m_irq_en;
	int                    flag_reads;
	int                    irq_cycles;

	ppu_timing_top #(
		.ADDR_W(12)
	) dut_i (
		.pclk(pclk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.hsync(hsync), .vsync(vsync), .vblank(vblank), .visible(visible), .irq(irq)
	);

	always #(CLK_NS / 2) pclk = ~pclk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
			stop_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, want));
	endtask

	task automatic check_data(input string name, input ppu_regs_pkg::apb_data_t got,
		input ppu_regs_pkg::apb_data_t want);
		if (got !== want)
			stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, want));
	endtask

	task automatic check_err(input logic got, input logic want);
		if (got !== want)
			stop_run($sformatf("error at %0t ns: pslverr is %b, expected %b", $time, got, want));
	endtask

	function automatic ppu_regs_pkg::apb_addr_t pick_offset();
		case ($urandom % 4)
			0: return ppu_regs_pkg::CTRL_OFS;
			1: return ppu_regs_pkg::STATUS_OFS;
			2: return ppu_regs_pkg::POS_OFS;
			default: return ppu_regs_pkg::apb_addr_t'($urandom); // mostly unmapped.
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// one clock of the timing rules
	////////////////////////////////////////////////////////////

	task automatic advance_model(input logic access);
		logic status_rd;
		status_rd = access && !pwrite && paddr == ppu_regs_pkg::STATUS_OFS;
		m_irq = m_flag & m_irq_en;
		if (m_vblank && !m_vblank_q)
			m_flag = 1'b1; // setting wins over a clearing read.
		else if (status_rd)
			m_flag = 1'b0;
		m_vblank_q = m_vblank;
		m_visible = (m_h < ppu_timing_pkg::H_VISIBLE) && !m_vblank && m_render;
		if (access && pwrite && paddr == ppu_regs_pkg::CTRL_OFS) begin
			m_render = pwdata[ppu_regs_pkg::CTRL_RENDER_BIT];
			m_irq_en = pwdata[ppu_regs_pkg::CTRL_IRQ_EN_BIT];
		end
		m_vsync = (m_v == ppu_timing_pkg::V_VSYNC);
		if (m_h == ppu_timing_pkg::H_HSYNC_ON)
			m_hsync = 1'b1;
		else if (m_h == ppu_timing_pkg::H_HSYNC_OFF)
			m_hsync = 1'b0;
		if (m_h == ppu_timing_pkg::H_VISIBLE && m_v == ppu_timing_pkg::V_VB_START)
			m_vblank = 1'b1;
		else if (m_h == ppu_timing_pkg::H_VISIBLE && m_v == ppu_timing_pkg::V_LINES - 1)
			m_vblank = 1'b0;
		if (m_h == ppu_timing_pkg::H_DOTS - 1) begin
			m_h = '0;
			m_v = (m_v == ppu_timing_pkg::V_LINES - 1) ? '0 : m_v + 1'b1;
		end else begin
			m_h = m_h + 1'b1;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		stop_run("timeout: the three frames did not complete in the expected time");
	end

	initial begin
		ppu_regs_pkg::apb_data_t want_rd;
		logic access;
		logic mapped;
		int phase;
		int gap;
		void'($urandom(12));
		pclk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		m_hsync = 1'b0;
		m_vsync = 1'b0;
		m_vblank = 1'b0;
		m_vblank_q = 1'b0;
		m_visible = 1'b0;
		m_flag = 1'b0;
		m_irq = 1'b0;
		m_render = 1'b0;
		m_irq_en = 1'b0;
		m_h = '0;
		m_v = '0;
		flag_reads = 0;
		irq_cycles = 0;
		phase = 0;
		gap = 1 + int'($urandom % 20);
		repeat (2) @(posedge pclk);
		rst_n <= 1'b1;

		repeat (RUN_CYCLES) begin
			@(posedge pclk);
			access = psel & penable;
			mapped = paddr == ppu_regs_pkg::CTRL_OFS || paddr == ppu_regs_pkg::STATUS_OFS
				|| paddr == ppu_regs_pkg::POS_OFS;
			check_bit("hsync", hsync, m_hsync);
			check_bit("vsync", vsync, m_vsync);
			check_bit("vblank", vblank, m_vblank);
			check_bit("visible", visible, m_visible);
			check_bit("irq", irq, m_irq);
			if (access) begin
				check_bit("pready", pready, 1'b1);
				check_err(pslverr, !mapped);
				if (!pwrite && mapped) begin
					want_rd = '0;
					if (paddr == ppu_regs_pkg::CTRL_OFS) begin
						want_rd[ppu_regs_pkg::CTRL_RENDER_BIT] = m_render;
						want_rd[ppu_regs_pkg::CTRL_IRQ_EN_BIT] = m_irq_en;
					end else if (paddr == ppu_regs_pkg::STATUS_OFS) begin
						want_rd[ppu_regs_pkg::STATUS_VBL_BIT] = m_flag;
						flag_reads += int'(m_flag);
					end else begin
						want_rd[8:0] = m_h;
						want_rd[ppu_regs_pkg::POS_V_LSB +: 9] = m_v;
					end
					check_data("prdata", prdata, want_rd);
				end
			end
			irq_cycles += int'(irq);
			advance_model(access);

			// the APB master runs an idle gap, then a setup phase and an access phase.
			if (phase == 0) begin
				gap--;
				if (gap == 0) begin
					psel <= 1'b1;
					penable <= 1'b0;
					pwrite <= ($urandom % 2) == 1;
					paddr <= pick_offset();
					pwdata <= $urandom;
					phase = 1;
				end
			end else if (phase == 1) begin
				penable <= 1'b1;
				phase = 2;
			end else begin
				psel <= 1'b0;
				penable <= 1'b0;
				gap = 1 + int'($urandom % 20);
				phase = 0;
			end
		end

		if (flag_reads == 0)
			stop_run("no STATUS read ever returned the vblank flag set");
		else if (irq_cycles == 0)
			stop_run("irq was never raised during the run");
		else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
source/ppu_timing_pkg.sv
source/ppu_regs_pkg.sv
source/hv_counters.sv
source/h_decoder.sv
source/v_decoder.sv
source/sync_gen.sv
source/ppu_apb_regs.sv
source/ppu_timing_top.sv
dv/ppu_timing_tb.sv
